/* proc_trace.txt */
# I <instruction word, hex>
# E <unit A=ALU M=multiplier X=illegal> <rd, decimal> <value, hex>
I 12300093
E A 01 00000123
I FF900113
E A 02 FFFFFFF9
I 002081B3
E A 03 0000011C
I 40208233
E A 04 0000012A
I 0020F2B3
E A 05 00000121
I 0020E333
E A 06 FFFFFFFB
I 0020C3B3
E A 07 FFFFFEDA
I 00209433
E A 08 46000000
I 001154B3
E A 09 1FFFFFFF
I 40115533
E A 10 FFFFFFFF
I 001125B3
E A 11 00000001
I 00113633
E A 12 00000000
# Immediate forms
I 0F017693
E A 13 000000F0
I F000E713
E A 14 FFFFFF23
I FFF0C793
E A 15 FFFFFEDC
I 00409813
E A 16 00001230
I 01C15893
E A 17 0000000F
I 40115913
E A 18 FFFFFFFC
I 12C0A993
E A 19 00000001
I FFF13A13
E A 20 00000001
# mul x21, then an independent add and a dependent add
I 02208AB3
E M 21 FFFFF80B
I 00108B33
E A 22 00000246
I 001A8BB3
E A 23 FFFFF92E
I 03180C33
E M 24 000110D0
# rd x0 still shows a record on o_alu_wb but is never stored
I 00508013
E A 00 00000128
I 00100CB3
E A 25 00000123
# Unknown opcode with rd x26, then a read of x26
I 00000D7F
E X 00 00000000
I 001D0DB3
E A 27 00000123
# mulh is not supported
I 02209E33
E X 00 00000000

/* sources.f */
+incdir+.
isa_pkg.sv
proc_pkg.sv
inst_queue.sv
proc_dispatch.sv
alu_unit.sv
muldiv_unit.sv
int_regfile.sv
proc_top.sv
tb_clkgen.sv
tb_proc.sv

/* Makefile */
# Verilator flow for the processing stage

VERILATOR  ?= verilator
FILELIST   ?= sources.f
TB_TOP     ?= tb_proc
RTL_TOP    ?= proc_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_proc.sv */
// Processing stage testbench, trace driven

`timescale 1ns/1ns
`default_nettype none

`include "proc_consts.svh"

module tb_proc
    import isa_pkg::*, proc_pkg::*;
();

    localparam string TRACE_FILE = "proc_trace.txt";

    logic        aclk;
    logic        aresetn;
    logic        inst_valid;
    inst_u       inst;
    logic        credit;
    logic        illegal;
    wb_t         alu_wb;
    wb_t         mul_wb;

    logic [31:0] inst_list [$];
    wb_t         exp_alu [$];
    wb_t         exp_mul [$];
    int          mul_need [$];
    int          illegal_pending = 0;
    int          sent_count      = 0;
    int          returned_count  = 0;
    int          retired_count   = 0;
    int          alu_done_count  = 0;
    int          pass_count      = 0;
    int          fail_count      = 0;
    int          watchdog_limit  = 0;
    bit          trace_loaded    = 1'b0;
    bit          credit_fault    = 1'b0;
    integer      seed            = 32'h5bb6143b;

    tb_clkgen i_clkgen (
        .o_aclk    (aclk),
        .o_aresetn (aresetn)
    );

    proc_top i_dut (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_inst_valid (inst_valid),
        .i_inst       (inst),
        .o_credit     (credit),
        .o_illegal    (illegal),
        .o_alu_wb     (alu_wb),
        .o_mul_wb     (mul_wb)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Trace loading
    ////////////////////////////////////////////////////////////////////////////

    // True when the word reads or writes register r
    function automatic bit touches_reg(input inst_u word, input int r);
        bit hit;
        hit = (word.r.rs1 == 5'(r)) || (word.r.rd == 5'(r));
        if (word.r.opcode == OPC_ARITH_R) begin
            hit = hit || (word.r.rs2 == 5'(r));
        end
        return hit;
    endfunction

    // I lines hold instruction words, E lines hold one expected result each
    task automatic load_trace(output bit ok);
        int          fd;
        string       line;
        byte         kind;
        byte         unit;
        int          rd;
        logic [31:0] value;
        wb_t         rec;
        bit          watch_next;
        int          watch_rd;
        ok         = 1'b1;
        watch_next = 1'b0;
        watch_rd   = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open trace file %s", TRACE_FILE);
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = (line.len() < 2) ? "#" : line.getc(0);
                if (kind == "I") begin
                    if ($sscanf(line, "I %h", value) == 1) begin
                        inst_list.push_back(value);
                    end else begin
                        ok = 1'b0;
                    end
                end else if (kind == "E" && line.len() > 4) begin
                    unit = line.getc(2);
                    if ($sscanf(line.substr(4, line.len() - 1), "%d %h", rd, value) != 2) begin
                        ok = 1'b0;
                    end
                    rec = '{valid: 1'b1, rd: 5'(rd), data: value};
                    case (unit)
                        "A": begin
                            // An independent ALU right behind a multiply overtakes it
                            if (watch_next && inst_list.size() != 0 &&
                                !touches_reg(inst_list[inst_list.size() - 1], watch_rd)) begin
                                mul_need[mul_need.size() - 1] = mul_need[mul_need.size() - 1] + 1;
                            end
                            exp_alu.push_back(rec);
                        end
                        "M": begin
                            mul_need.push_back(exp_alu.size());
                            exp_mul.push_back(rec);
                        end
                        "X":     illegal_pending++;
                        default: ok = 1'b0;
                    endcase
                    watch_next = (unit == "M");
                    watch_rd   = rd;
                end else if (kind != "#") begin
                    ok = 1'b0;
                end
                if (!ok) begin
                    $display("trace line not understood: %s", line);
                    break;
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_wb(input string name, input wb_t got, input wb_t want);
        if (got !== want) begin
            $display("ERROR %0t %s expected rd=%0d data=%08h got rd=%0d data=%08h",
                     $time, name, want.rd, want.data, got.rd, got.data);
            fail_count++;
        end else begin
            $display("ok    %0t %s rd=%0d data=%08h", $time, name, got.rd, got.data);
            pass_count++;
        end
    endtask

    task automatic report_unexpected(input string name, input wb_t got);
        $display("unexpected writeback on %s at %0t ns, rd=%0d data=%08h",
                 name, $time, got.rd, got.data);
        fail_count++;
    endtask

    // ALU results due ahead of a multiply must be out when its product appears
    task automatic check_mul_order();
        int need;
        if (mul_need.size() != 0) begin
            need = mul_need.pop_front();
            if (alu_done_count < need) begin
                $display("o_mul_wb at %0t ns came before %0d of the ALU results due ahead of it",
                         $time, need - alu_done_count);
                fail_count++;
            end else begin
                $display("ok    %0t o_mul_wb after %0d ALU results", $time, alu_done_count);
                pass_count++;
            end
        end
    endtask

    // Each pulse retires one expected illegal instruction
    task automatic check_illegal(input logic pulse);
        if (pulse) begin
            if (illegal_pending == 0) begin
                $display("o_illegal pulsed at %0t ns with no illegal instruction pending",
                         $time);
                fail_count++;
            end else begin
                illegal_pending--;
                $display("ok    %0t o_illegal pulse", $time);
                pass_count++;
            end
        end
    endtask

    task automatic check_credits();
        if (returned_count != sent_count) begin
            $display("ERROR %0t o_credit expected %0d credits got %0d",
                     $time, sent_count, returned_count);
            fail_count++;
        end else begin
            $display("ok    %0t o_credit %0d credits for %0d instructions",
                     $time, returned_count, sent_count);
            pass_count++;
        end
    endtask

    function automatic bit drained();
        return exp_alu.size() == 0 && exp_mul.size() == 0 && illegal_pending == 0;
    endfunction

    // Outputs sampled mid-cycle, away from the clock edge
    always @(negedge aclk) begin
        if (aresetn) begin
            if (alu_wb.valid) begin
                alu_done_count++;
                retired_count++;
                if (exp_alu.size() == 0) begin
                    report_unexpected("o_alu_wb", alu_wb);
                end else begin
                    check_wb("o_alu_wb", alu_wb, exp_alu.pop_front());
                end
            end
            if (mul_wb.valid) begin
                retired_count++;
                check_mul_order();
                if (exp_mul.size() == 0) begin
                    report_unexpected("o_mul_wb", mul_wb);
                end else begin
                    check_wb("o_mul_wb", mul_wb, exp_mul.pop_front());
                end
            end
            check_illegal(illegal);
            if (illegal) begin
                retired_count++;
            end
            if (credit) begin
                returned_count++;
            end
            // A full queue plus one running multiply may still lack results
            if (!credit_fault && (returned_count > sent_count ||
                                  sent_count - retired_count > `QUEUE_DEPTH + 1)) begin
                $display("credit fault at %0t ns, %0d sent, %0d returned, %0d retired",
                         $time, sent_count, returned_count, retired_count);
                credit_fault = 1'b1;
                fail_count++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge aclk);
            #1;
        end
    endtask

    // Upstream side of the credit loop, one word per held credit
    task automatic send_inst(input logic [31:0] word);
        while (sent_count - returned_count >= `QUEUE_DEPTH) begin
            idle_cycles(1);
        end
        inst_valid = 1'b1;
        inst       = word;
        sent_count++;
        idle_cycles(1);
        inst_valid = 1'b0;
        inst       = '0;
    endtask

    initial begin
        bit loaded;
        int gap;
        inst_valid = 1'b0;
        inst       = '0;
        load_trace(loaded);
        if (!loaded) begin
            $display("sim failed");
            $finish;
        end else begin
            watchdog_limit = inst_list.size() * (`MUL_CYCLES + 8) + 100;
            trace_loaded   = 1'b1;
            wait (aresetn === 1'b1);
            idle_cycles(1);
            foreach (inst_list[k]) begin
                gap = $unsigned($random(seed)) % 4;
                idle_cycles(gap);
                send_inst(inst_list[k]);
            end
            while (!drained()) begin
                idle_cycles(1);
            end
            // A few spare cycles to catch stray writebacks
            idle_cycles(4);
            check_credits();
            $display("tests: %0d passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

    initial begin
        wait (trace_loaded);
        repeat (watchdog_limit) @(posedge aclk);
        $display("timeout after %0d cycles with %0d ALU, %0d MUL and %0d illegal results %s",
                 watchdog_limit, exp_alu.size(), exp_mul.size(), illegal_pending,
                 "still outstanding");
        $display("credits returned %0d of %0d sent", returned_count, sent_count);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clkgen.sv */
// Testbench clock and reset

`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 3
) (
    output logic o_aclk,
    output logic o_aresetn
);

    initial begin
        o_aclk = 1'b0;
        forever #HALF_PERIOD o_aclk = ~o_aclk;
    end

    // Reset low for RESET_CYCLES rising edges, released just after an edge
    initial begin
        o_aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_aclk);
        #1;
        o_aresetn = 1'b1;
    end

endmodule

`default_nettype wire

/* proc_top.sv */
// RV32I processing stage top

`timescale 1ns/1ns
`default_nettype none

`include "proc_consts.svh"

module proc_top
    import isa_pkg::*, proc_pkg::*;
(
    input  wire        aclk,
    input  wire        aresetn,
    input  wire        i_inst_valid,
    input  wire inst_u i_inst,
    output logic       o_credit,
    output logic       o_illegal,
    output wb_t        o_alu_wb,
    output wb_t        o_mul_wb
);

    logic             q_valid;
    inst_u            q_inst;
    logic             q_ready;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    issue_t           alu_issue;
    issue_t           mul_issue;
    logic             mul_busy;
    logic [4:0]       mul_rd;

    inst_queue i_queue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .i_valid  (i_inst_valid),
        .i_inst   (i_inst),
        .o_valid  (q_valid),
        .o_inst   (q_inst),
        .i_ready  (q_ready),
        .o_credit (o_credit)
    );

    proc_dispatch i_dispatch (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_valid     (q_valid),
        .i_inst      (q_inst),
        .o_ready     (q_ready),
        .o_rs1_addr  (rs1_addr),
        .o_rs2_addr  (rs2_addr),
        .i_rs1_val   (rs1_val),
        .i_rs2_val   (rs2_val),
        .o_alu_issue (alu_issue),
        .o_mul_issue (mul_issue),
        .i_mul_busy  (mul_busy),
        .i_mul_rd    (mul_rd),
        .o_illegal   (o_illegal)
    );

    alu_unit i_alu (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_issue (alu_issue),
        .o_wb    (o_alu_wb)
    );

    muldiv_unit i_mul (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_issue (mul_issue),
        .o_busy  (mul_busy),
        .o_rd    (mul_rd),
        .o_wb    (o_mul_wb)
    );

    // Port 0 takes ALU results, port 1 multiplier results
    int_regfile i_regfile (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .o_rs1_val  (rs1_val),
        .o_rs2_val  (rs2_val),
        .i_wb0      (o_alu_wb),
        .i_wb1      (o_mul_wb)
    );

endmodule

`default_nettype wire

/* int_regfile.sv */
// Integer register file, two write ports

`timescale 1ns/1ns
`default_nettype none

`include "proc_consts.svh"

module int_regfile
    import proc_pkg::*;
(
    input  wire              aclk,
    input  wire              aresetn,
    input  wire [4:0]        i_rs1_addr,
    input  wire [4:0]        i_rs2_addr,
    output logic [`XLEN-1:0] o_rs1_val,
    output logic [`XLEN-1:0] o_rs2_val,
    input  wire wb_t         i_wb0,
    input  wire wb_t         i_wb1
);

    logic [`XLEN-1:0] regs [`NB_INT_REG];

    // x0 first, then same-cycle writes, then the stored value
    function automatic logic [`XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (i_wb0.valid && i_wb0.rd == addr) begin
            return i_wb0.data;
        end
        if (i_wb1.valid && i_wb1.rd == addr) begin
            return i_wb1.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rs1_val = read_port(i_rs1_addr);
        o_rs2_val = read_port(i_rs2_addr);
    end

    // The dispatcher never lets both ports target one register together
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < `NB_INT_REG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_wb0.valid && i_wb0.rd != 5'd0) begin
                regs[i_wb0.rd] <= i_wb0.data;
            end
            if (i_wb1.valid && i_wb1.rd != 5'd0) begin
                regs[i_wb1.rd] <= i_wb1.data;
            end
        end
    end

endmodule

`default_nettype wire

/* muldiv_unit.sv */
// Iterative shift-add multiplier

`timescale 1ns/1ns
`default_nettype none

`include "proc_consts.svh"

module muldiv_unit
    import proc_pkg::*;
(
    input  wire         aclk,
    input  wire         aresetn,
    input  wire issue_t i_issue,
    output logic        o_busy,
    output logic [4:0]  o_rd,
    output wb_t         o_wb
);

    localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

    logic [CNT_W-1:0] remain;
    logic             accept;
    logic [`XLEN-1:0] mcand;
    logic [`XLEN-1:0] mplier;
    logic [`XLEN-1:0] acc;
    logic [`XLEN-1:0] acc_next;
    logic             wb_valid;
    logic [`XLEN-1:0] wb_data;

    assign o_busy   = (remain != '0);
    assign accept   = i_issue.valid && !o_busy;
    assign acc_next = acc + (mplier[0] ? mcand : '0);

    ////////////////////////////////////////////////////////////////////////////
    // Iteration control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            remain   <= '0;
            wb_valid <= 1'b0;
        end else begin
            if (accept) begin
                remain <= CNT_W'(`MUL_CYCLES);
            end else if (o_busy) begin
                remain <= remain - 1'b1;
            end
            // Last iteration lands in the writeback register
            wb_valid <= (remain == CNT_W'(1));
        end
    end

    // One partial product per cycle, low XLEN bits only
    always_ff @(posedge aclk) begin
        if (accept) begin
            mcand  <= i_issue.op_a;
            mplier <= i_issue.op_b;
            acc    <= '0;
            o_rd   <= i_issue.rd;
        end else if (o_busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
        if (remain == CNT_W'(1)) begin
            wb_data <= acc_next;
        end
    end

    assign o_wb = '{valid: wb_valid, rd: o_rd, data: wb_data};

endmodule

`default_nettype wire

/* alu_unit.sv */
// Single-cycle integer ALU

`timescale 1ns/1ns
`default_nettype none

`include "proc_consts.svh"

module alu_unit
    import proc_pkg::*;
(
    input  wire         aclk,
    input  wire         aresetn,
    input  wire issue_t i_issue,
    output wb_t         o_wb
);

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] result;
    logic             wb_valid;
    logic [4:0]       wb_rd;
    logic [`XLEN-1:0] wb_data;

    assign a     = i_issue.op_a;
    assign b     = i_issue.op_b;
    assign shamt = b[4:0];

    always_comb begin
        case (i_issue.alu_op)
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, a < b};
            default:  result = a + b;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= i_issue.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_issue.valid) begin
            wb_rd   <= i_issue.rd;
            wb_data <= result;
        end
    end

    assign o_wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

endmodule

`default_nettype wire

/* proc_dispatch.sv */
// Decode, scoreboard and issue

`timescale 1ns/1ns
`default_nettype none

`include "proc_consts.svh"

module proc_dispatch
    import isa_pkg::*, proc_pkg::*;
(
    input  wire              aclk,
    input  wire              aresetn,
    input  wire              i_valid,
    input  wire inst_u       i_inst,
    output logic             o_ready,
    output logic [4:0]       o_rs1_addr,
    output logic [4:0]       o_rs2_addr,
    input  wire [`XLEN-1:0]  i_rs1_val,
    input  wire [`XLEN-1:0]  i_rs2_val,
    output issue_t           o_alu_issue,
    output issue_t           o_mul_issue,
    input  wire              i_mul_busy,
    input  wire [4:0]        i_mul_rd,
    output logic             o_illegal
);

    logic             is_alu;
    logic             is_mul;
    logic             uses_rs2;
    logic             legal;
    logic             hazard;
    logic             issue;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] imm_sext;
    issue_t           issue_rec;

    // funct3 meaning shared by register and immediate forms
    function automatic alu_op_e f3_to_op(input logic [2:0] f3);
        case (f3)
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        is_alu   = 1'b0;
        is_mul   = 1'b0;
        uses_rs2 = 1'b0;
        alu_op   = f3_to_op(i_inst.r.funct3);
        if (i_inst.r.opcode == OPC_MULDIV && i_inst.r.funct7 == F7_MULDIV) begin
            // Only the low product half is supported
            is_mul   = (i_inst.r.funct3 == F3_MUL);
            uses_rs2 = 1'b1;
        end else if (i_inst.r.opcode == OPC_ARITH_R) begin
            uses_rs2 = 1'b1;
            if (i_inst.r.funct7 == F7_BASE) begin
                is_alu = 1'b1;
            end else if (i_inst.r.funct7 == F7_ALT) begin
                is_alu = (i_inst.r.funct3 == F3_ADD) || (i_inst.r.funct3 == F3_SR);
                alu_op = (i_inst.r.funct3 == F3_ADD) ? ALU_SUB : ALU_SRA;
            end
        end else if (i_inst.i.opcode == OPC_ARITH_I) begin
            is_alu = 1'b1;
            // Shift immediates carry funct7 in the upper imm bits
            if (i_inst.i.funct3 == F3_SLL) begin
                is_alu = (i_inst.i.imm12[11:5] == F7_BASE);
            end else if (i_inst.i.funct3 == F3_SR) begin
                is_alu = (i_inst.i.imm12[11:5] == F7_BASE) ||
                         (i_inst.i.imm12[11:5] == F7_ALT);
                alu_op = (i_inst.i.imm12[11:5] == F7_ALT) ? ALU_SRA : ALU_SRL;
            end
        end
    end

    assign legal    = is_alu || is_mul;
    assign imm_sext = {{(`XLEN-12){i_inst.i.imm12[11]}}, i_inst.i.imm12};

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard and issue
    ////////////////////////////////////////////////////////////////////////////

    // RAW and WAW against the pending multiply, plus a single multiplier slot
    assign hazard = i_mul_busy && (is_mul ||
                                   i_inst.r.rs1 == i_mul_rd ||
                                   (uses_rs2 && i_inst.r.rs2 == i_mul_rd) ||
                                   i_inst.r.rd == i_mul_rd);

    // Illegal words are consumed without waiting
    assign o_ready = !legal || !hazard;
    assign issue   = i_valid && legal && !hazard;

    assign o_rs1_addr = i_inst.r.rs1;
    assign o_rs2_addr = i_inst.r.rs2;

    assign issue_rec.valid  = issue;
    assign issue_rec.alu_op = alu_op;
    assign issue_rec.rd     = i_inst.r.rd;
    assign issue_rec.op_a   = i_rs1_val;
    assign issue_rec.op_b   = uses_rs2 ? i_rs2_val : imm_sext;

    always_comb begin
        o_alu_issue       = issue_rec;
        o_alu_issue.valid = issue_rec.valid && is_alu;
        o_mul_issue       = issue_rec;
        o_mul_issue.valid = issue_rec.valid && is_mul;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_illegal <= 1'b0;
        end else begin
            o_illegal <= i_valid && !legal;
        end
    end

endmodule

`default_nettype wire

/* inst_queue.sv */
// Credit-based instruction FIFO

`timescale 1ns/1ns
`default_nettype none

`include "proc_consts.svh"

module inst_queue
    import isa_pkg::*;
(
    input  wire        aclk,
    input  wire        aresetn,
    input  wire        i_valid,
    input  wire inst_u i_inst,
    output logic       o_valid,
    output inst_u      o_inst,
    input  wire        i_ready,
    output logic       o_credit
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    inst_u            mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Upstream only sends with a credit in hand, so a push always finds room
    assign push    = i_valid;
    assign pop     = o_valid && i_ready;
    assign o_valid = (count != '0);
    assign o_inst  = mem[rd_ptr];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // One credit back per released entry
            o_credit <= pop;
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= i_inst;
        end
    end

endmodule

`default_nettype wire

/* proc_pkg.sv */
// Issue and writeback records

`default_nettype none

`include "proc_consts.svh"

package proc_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // Operand b holds rs2 or the sign-extended immediate
    typedef struct packed {
        logic             valid;
        alu_op_e          alu_op;
        logic [4:0]       rd;
        logic [`XLEN-1:0] op_a;
        logic [`XLEN-1:0] op_b;
    } issue_t;

    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* isa_pkg.sv */
// RV32I instruction formats

`default_nettype none

package isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_ARITH_R = 7'b0110011;
    localparam logic [6:0] OPC_ARITH_I = 7'b0010011;
    localparam logic [6:0] OPC_MULDIV  = 7'b0110011;

    // funct7 selects base, alternate (sub/sra) or M-extension group
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_MUL  = 3'b000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_inst_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_inst_t;

    // Same word seen as register or immediate form
    typedef union packed {
        r_inst_t r;
        i_inst_t i;
    } inst_u;

endpackage

`default_nettype wire

/* proc_consts.svh */
// Processing stage constants

`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

// Integer data path width
`define XLEN 32

// Architectural integer registers
`define NB_INT_REG 32

// Instruction queue entries, also the credits granted upstream after reset
`define QUEUE_DEPTH 4

// Shift-add iterations per multiply
`define MUL_CYCLES 32

`endif
